//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD  = 3'b000; // also sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl / sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_WORD = 3'b010; // lw / sw only

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    localparam logic [11:0] IMM_EBREAK = 12'h001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_t;

endpackage

//--- hdl/core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_WB,
        S_HALT
    } ctrl_state_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] imm;
        alu_op_t         alu_op;
        logic            alu_src_imm; // operand b from imm
        logic            a_is_pc;     // auipc
        logic            reg_write;
        logic            is_load;
        logic            is_store;
        logic            is_branch;
        logic            is_jal;
        logic            is_jalr;
        logic [2:0]      branch_f3;
        logic            is_ebreak;
        logic            invalid;
    } decode_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            we;
    } mem_req_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
        logic            we;
    } retire_t;

endpackage

//--- hdl/idu.sv
`timescale 1ns/100ps
module idu
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  inst_t   inst,
    output decode_t dec
);
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;

    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.u.imm, 12'b0};
    assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                    inst.j.imm11, inst.j.imm10_1, 1'b0};

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec           = '0;
        dec.rd        = inst.r.rd;
        dec.rs1       = inst.r.rs1;
        dec.rs2       = inst.r.rs2;
        dec.branch_f3 = funct3;
        dec.alu_op    = ALU_ADD;
        case (opcode)
            OPC_LUI: begin
                dec.rs1         = '0; // x0 + imm
                dec.imm         = imm_u;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_AUIPC: begin
                dec.imm         = imm_u;
                dec.a_is_pc     = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_JALR: begin
                dec.imm       = imm_i;
                dec.is_jalr   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_BRANCH: begin
                dec.rd        = '0;
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.invalid   = !(funct3 inside {F3_BEQ, F3_BNE, F3_BLT,
                                                 F3_BGE, F3_BLTU, F3_BGEU});
            end
            OPC_LOAD: begin
                dec.imm         = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.is_load     = 1'b1;
                dec.reg_write   = 1'b1;
                dec.invalid     = (funct3 != F3_WORD);
            end
            OPC_STORE: begin
                dec.rd          = '0;
                dec.imm         = imm_s;
                dec.alu_src_imm = 1'b1;
                dec.is_store    = 1'b1;
                dec.invalid     = (funct3 != F3_WORD);
            end
            OPC_OP_IMM: begin
                dec.imm         = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                // only srai uses the alt bit here, addi has no sub
                dec.alu_op      = alu_sel(funct3, (funct3 == F3_SR) &&
                                                  (inst.r.funct7 == F7_ALT));
            end
            OPC_OP: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_sel(funct3, inst.r.funct7 == F7_ALT);
                dec.invalid   = !(inst.r.funct7 inside {F7_BASE, F7_ALT});
            end
            OPC_SYSTEM: begin
                if (inst.i.imm == IMM_EBREAK && funct3 == 3'b000 &&
                    inst.i.rs1 == 5'd0 && inst.i.rd == 5'd0) begin
                    dec.is_ebreak = 1'b1;
                end else begin
                    dec.invalid = 1'b1; // ecall, csr etc
                end
            end
            default: dec.invalid = 1'b1;
        endcase
    end

endmodule

//--- hdl/regfile.sv
`timescale 1ns/100ps
module regfile
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic            we,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);
    logic [XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- hdl/exu.sv
`timescale 1ns/100ps
module exu
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  decode_t         dec,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rdata1,
    input  logic [XLEN-1:0] rdata2,
    input  logic [XLEN-1:0] data_rdata,
    output logic [XLEN-1:0] alu_result,
    output logic            branch_taken,
    output logic [XLEN-1:0] wb_value
);
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic            cond;

    assign op_a  = dec.a_is_pc ? pc : rdata1;
    assign op_b  = dec.alu_src_imm ? dec.imm : rdata2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = '0;
        endcase
    end

    // comparator works on the raw register pair
    always_comb begin
        case (dec.branch_f3)
            F3_BEQ:  cond = (rdata1 == rdata2);
            F3_BNE:  cond = (rdata1 != rdata2);
            F3_BLT:  cond = ($signed(rdata1) < $signed(rdata2));
            F3_BGE:  cond = ($signed(rdata1) >= $signed(rdata2));
            F3_BLTU: cond = (rdata1 < rdata2);
            F3_BGEU: cond = (rdata1 >= rdata2);
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = dec.is_branch && cond;

    assign wb_value = (dec.is_jal || dec.is_jalr) ? pc + XLEN'(4) : // link
                      dec.is_load                  ? data_rdata    :
                                                     alu_result;

endmodule

//--- hdl/pc_unit.sv
`timescale 1ns/100ps
module pc_unit
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            pc_update,
    input  logic            take_target,
    input  logic            jalr_target,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] rs1_value,
    output logic [XLEN-1:0] pc
);
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] jalr_sum;

    assign jalr_sum = rs1_value + imm;

    always_comb begin
        if (jalr_target) begin
            pc_next = {jalr_sum[XLEN-1:1], 1'b0}; // lsb cleared per spec
        end else if (take_target) begin
            pc_next = pc + imm;
        end else begin
            pc_next = pc + XLEN'(4);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (pc_update) begin
            pc <= pc_next;
        end
    end

endmodule

//--- hdl/core_ctrl.sv
`timescale 1ns/100ps
module core_ctrl
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  inst_t           inst_rdata,
    input  decode_t         dec,
    input  logic            branch_taken,
    input  logic [XLEN-1:0] alu_result,
    input  logic [XLEN-1:0] rdata2,
    input  logic [XLEN-1:0] wb_value,
    input  logic [XLEN-1:0] pc,
    output inst_t           inst,
    output logic            inst_req,
    output logic            data_req,
    output mem_req_t        mem_req,
    output logic            reg_we,
    output logic            pc_update,
    output logic            take_target,
    output logic            jalr_target,
    output logic            retire_valid,
    output retire_t         retire,
    output logic            halted,
    output logic            trap
);
    ctrl_state_t     state;
    ctrl_state_t     state_next;
    inst_t           ir;
    logic [XLEN-1:0] addr_q;

    // decoder sees the fetched word directly while in decode
    assign inst = (state == S_DECODE) ? inst_rdata : ir;

    always_comb begin
        case (state)
            S_FETCH:  state_next = inst_req ? S_DECODE : S_FETCH;
            S_DECODE: state_next = (dec.is_ebreak || dec.invalid) ? S_HALT : S_EXEC;
            S_EXEC:   state_next = (dec.is_load || dec.is_store) ? S_MEM : S_WB;
            S_MEM:    state_next = S_WB;
            S_WB:     state_next = S_FETCH;
            default:  state_next = S_HALT; // stays halted
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_FETCH;
            inst_req <= 1'b0;
            trap     <= 1'b0;
        end else begin
            state    <= state_next;
            inst_req <= (state_next == S_FETCH); // one pulse per fetch
            if (state == S_DECODE && dec.invalid) begin
                trap <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            ir <= inst_rdata;
        end
        if (state == S_EXEC) begin
            addr_q <= alu_result; // lw/sw address
        end
    end

    assign data_req      = (state == S_MEM);
    assign mem_req.addr  = addr_q;
    assign mem_req.wdata = rdata2;
    assign mem_req.we    = dec.is_store;

    assign reg_we      = (state == S_WB) && dec.reg_write;
    assign pc_update   = (state == S_WB);
    assign take_target = dec.is_jal || branch_taken;
    assign jalr_target = dec.is_jalr;

    assign retire_valid = (state == S_WB);
    assign retire.pc    = pc;
    assign retire.inst  = ir;
    assign retire.rd    = dec.rd;
    assign retire.wdata = wb_value;
    assign retire.we    = dec.reg_write && (dec.rd != 5'd0);

    assign halted = (state == S_HALT);

endmodule

//--- hdl/core_top.sv
`timescale 1ns/100ps
module core_top
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    output logic            inst_req,
    output logic [XLEN-1:0] inst_addr,
    input  inst_t           inst_rdata,
    output logic            data_req,
    output mem_req_t        mem_req,
    input  logic [XLEN-1:0] data_rdata,
    output logic            retire_valid,
    output retire_t         retire,
    output logic            halted,
    output logic            trap
);
    inst_t           inst;
    decode_t         dec;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] wb_value;
    logic            branch_taken;
    logic            reg_we;
    logic            pc_update;
    logic            take_target;
    logic            jalr_target;

    idu u_idu (
        .inst (inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rd     (dec.rd),
        .we     (reg_we),
        .wdata  (wb_value),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    exu u_exu (
        .dec          (dec),
        .pc           (inst_addr),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .data_rdata   (data_rdata),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .wb_value     (wb_value)
    );

    pc_unit u_pc_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .pc_update   (pc_update),
        .take_target (take_target),
        .jalr_target (jalr_target),
        .imm         (dec.imm),
        .rs1_value   (rdata1),
        .pc          (inst_addr)
    );

    core_ctrl u_core_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_rdata   (inst_rdata),
        .dec          (dec),
        .branch_taken (branch_taken),
        .alu_result   (alu_result),
        .rdata2       (rdata2),
        .wb_value     (wb_value),
        .pc           (inst_addr),
        .inst         (inst),
        .inst_req     (inst_req),
        .data_req     (data_req),
        .mem_req      (mem_req),
        .reg_we       (reg_we),
        .pc_update    (pc_update),
        .take_target  (take_target),
        .jalr_target  (jalr_target),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted),
        .trap         (trap)
    );

endmodule

//--- tb/tb_checker.sv
`timescale 1ns/100ps
module tb_checker
    import rv_isa_pkg::*;
    import core_pkg::*;
#(
    parameter int ROWS = 32
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            inst_req,
    input  logic [XLEN-1:0] inst_addr,
    input  logic            data_req,
    input  logic            retire_valid,
    input  retire_t         retire,
    input  logic            halted,
    input  logic            trap,
    input  logic [XLEN-1:0] exp_pc [ROWS],
    input  logic [31:0]     exp_inst [ROWS],
    input  logic [4:0]      exp_rd [ROWS],
    input  logic [XLEN-1:0] exp_wdata [ROWS],
    input  logic            exp_we [ROWS],
    input  logic            exp_last [ROWS],
    input  logic            exp_trap,
    output logic            done,
    output int              err_count
);
    int   row;
    int   age;          // counts from 1 in the inst_req cycle
    logic after_retire;
    logic halt_trap;
    logic mem_op;
    int   errors = 0; // kept across runs

    assign err_count = errors;
    assign mem_op    = exp_inst[row][6:0] inside {OPC_LOAD, OPC_STORE};

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: row %0d %s is %h, expected %h", $time, row, what, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row          <= 0;
            done         <= 1'b0;
            age          <= 0;
            after_retire <= 1'b0;
            halt_trap    <= 1'b0;
        end else begin
            if (inst_req) begin
                age <= 2;
            end else if (age != 0) begin
                age <= age + 1;
            end
            after_retire <= retire_valid;
            if (after_retire && !inst_req) begin
                $display("ERR %0t: no inst_req in the cycle after a retire", $time);
                errors++;
            end
            if (data_req !== (mem_op && age == 4)) begin // memory cycle of lw / sw only
                $display("ERR %0t: data_req is %b in cycle %0d of row %0d",
                         $time, data_req, age, row);
                errors++;
            end
            if (retire_valid) begin
                if (done || exp_last[row]) begin
                    $display("ERR %0t: unexpected retire at pc %h", $time, retire.pc);
                    errors++;
                end else begin
                    check_word("pc", retire.pc, exp_pc[row]);
                    check_word("inst", retire.inst, exp_inst[row]);
                    check_word("rd", 32'(retire.rd), 32'(exp_rd[row]));
                    check_word("we", 32'(retire.we), 32'(exp_we[row]));
                    if (exp_we[row]) begin
                        check_word("wdata", retire.wdata, exp_wdata[row]);
                    end
                    check_word("retire cycle", 32'(age), mem_op ? 32'd5 : 32'd4);
                    row <= row + 1;
                end
            end
            if (halted && !done) begin
                if (!exp_last[row]) begin
                    $display("ERR %0t: halted at row %0d before the last row", $time, row);
                    errors++;
                end
                check_word("halt pc", inst_addr, exp_pc[row]);
                check_word("halt cycle", 32'(age), 32'd3);
                check_word("trap", 32'(trap), 32'(exp_trap));
                halt_trap <= trap;
                done      <= 1'b1;
            end
            if (done && (!halted || trap !== halt_trap)) begin
                $display("ERR %0t: halted or trap changed after the halt", $time);
                errors++;
            end
        end
    end

endmodule

//--- tb/tb_top.sv
`timescale 1ns/100ps
module tb_top
    import rv_isa_pkg::*;
    import core_pkg::*;
();
    localparam int ROWS  = 32;
    localparam int DEPTH = 64;

    logic            clk;
    logic            arst_n;
    logic            inst_req;
    logic [XLEN-1:0] inst_addr;
    inst_t           inst_rdata;
    logic            data_req;
    mem_req_t        mem_req;
    logic [XLEN-1:0] data_rdata;
    logic            retire_valid;
    retire_t         retire;
    logic            halted;
    logic            trap;

    logic [31:0] imem [0:DEPTH-1];
    logic [31:0] dmem [0:DEPTH-1];
    logic [31:0] dmem_init [0:DEPTH-1]; // random preload for expected loads

    logic [XLEN-1:0] exp_pc [ROWS];
    logic [31:0]     exp_inst [ROWS];
    logic [4:0]      exp_rd [ROWS];
    logic [XLEN-1:0] exp_wdata [ROWS];
    logic            exp_we [ROWS];
    logic            exp_last [ROWS];
    logic            exp_trap;
    int              n_rows;

    logic chk_done;
    int   err_count;
    int   timeouts;
    int   cycles;
    int   limit;

    core_top uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_rdata   (inst_rdata),
        .data_req     (data_req),
        .mem_req      (mem_req),
        .data_rdata   (data_rdata),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted),
        .trap         (trap)
    );

    tb_checker #(.ROWS(ROWS)) u_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .data_req     (data_req),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted),
        .trap         (trap),
        .exp_pc       (exp_pc),
        .exp_inst     (exp_inst),
        .exp_rd       (exp_rd),
        .exp_wdata    (exp_wdata),
        .exp_we       (exp_we),
        .exp_last     (exp_last),
        .exp_trap     (exp_trap),
        .done         (chk_done),
        .err_count    (err_count)
    );

    always #4 clk = ~clk;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    // both memories answer one cycle after the request
    always @(posedge clk) begin : memories
        logic            fetch;
        logic [XLEN-1:0] fetch_addr;
        logic            dreq;
        mem_req_t        req;
        fetch      = inst_req;
        fetch_addr = inst_addr;
        dreq       = data_req;
        req        = mem_req;
        #1;
        if (dreq && req.we) begin
            dmem[req.addr[7:2]] = req.wdata;
        end
        if (dreq) begin
            data_rdata = dmem[req.addr[7:2]];
        end
        if (fetch) begin
            inst_rdata = imem[fetch_addr[7:2]];
        end
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic add_row(input logic [31:0] pc, input logic [31:0] word, input int rd,
                           input logic [31:0] wdata, input logic we, input logic last);
        exp_pc[n_rows]    = pc;
        exp_inst[n_rows]  = word;
        exp_rd[n_rows]    = rd[4:0];
        exp_wdata[n_rows] = wdata;
        exp_we[n_rows]    = we;
        exp_last[n_rows]  = last;
        n_rows++;
    endtask

    // rows in execution order
    // x3 = -5 and x5 = 7 feed the branches
    task automatic build_table(input logic trap_end);
        n_rows = 0;
        add_row(32'h00, enc_u(32'h12345, 1, OPC_LUI), 1, 32'h1234_5000, 1'b1, 1'b0);
        add_row(32'h04, enc_u(32'hfffff, 2, OPC_AUIPC), 2, 32'hffff_f004, 1'b1, 1'b0);
        add_row(32'h08, enc_i(-5, 0, F3_ADD, 3, OPC_OP_IMM), 3, 32'hffff_fffb, 1'b1, 1'b0);
        add_row(32'h0c, enc_i(-2048, 3, F3_ADD, 4, OPC_OP_IMM), 4, 32'hffff_f7fb, 1'b1, 1'b0);
        add_row(32'h10, enc_i(7, 0, F3_ADD, 5, OPC_OP_IMM), 5, 32'h0000_0007, 1'b1, 1'b0);
        add_row(32'h14, enc_r(F7_ALT, 3, 5, F3_ADD, 6), 6, 32'h0000_000c, 1'b1, 1'b0);
        add_row(32'h18, enc_r(F7_ALT, 5, 4, F3_SR, 7), 7, 32'hffff_ffef, 1'b1, 1'b0);
        add_row(32'h1c, enc_r(F7_BASE, 5, 3, F3_SLT, 8), 8, 32'h0000_0001, 1'b1, 1'b0);
        add_row(32'h20, enc_r(F7_BASE, 5, 3, F3_SLTU, 9), 9, 32'h0000_0000, 1'b1, 1'b0);
        add_row(32'h24, enc_r(F7_BASE, 5, 5, F3_ADD, 0), 0, 32'h0, 1'b0, 1'b0); // x0 stays 0
        add_row(32'h28, enc_r(F7_BASE, 5, 0, F3_ADD, 10), 10, 32'h0000_0007, 1'b1, 1'b0);
        add_row(32'h2c, enc_b(8, 10, 5, F3_BEQ), 0, 32'h0, 1'b0, 1'b0);  // taken
        add_row(32'h34, enc_b(8, 10, 5, F3_BNE), 0, 32'h0, 1'b0, 1'b0);
        add_row(32'h38, enc_b(8, 5, 3, F3_BLT), 0, 32'h0, 1'b0, 1'b0);   // taken
        add_row(32'h40, enc_b(8, 5, 3, F3_BGE), 0, 32'h0, 1'b0, 1'b0);
        add_row(32'h44, enc_b(8, 5, 3, F3_BLTU), 0, 32'h0, 1'b0, 1'b0);
        add_row(32'h48, enc_b(8, 5, 3, F3_BGEU), 0, 32'h0, 1'b0, 1'b0);  // taken
        add_row(32'h50, enc_b(8, 3, 5, F3_BEQ), 0, 32'h0, 1'b0, 1'b0);
        add_row(32'h54, enc_b(8, 3, 5, F3_BNE), 0, 32'h0, 1'b0, 1'b0);   // taken
        add_row(32'h5c, enc_b(8, 3, 5, F3_BLT), 0, 32'h0, 1'b0, 1'b0);
        add_row(32'h60, enc_b(8, 3, 5, F3_BGE), 0, 32'h0, 1'b0, 1'b0);   // taken
        add_row(32'h68, enc_b(8, 3, 5, F3_BLTU), 0, 32'h0, 1'b0, 1'b0);  // taken
        add_row(32'h70, enc_b(8, 3, 5, F3_BGEU), 0, 32'h0, 1'b0, 1'b0);
        add_row(32'h74, enc_j(12, 12), 12, 32'h0000_0078, 1'b1, 1'b0);
        add_row(32'h80, enc_i(17, 12, 3'b000, 14, OPC_JALR), 14, 32'h0000_0084, 1'b1, 1'b0);
        add_row(32'h88, enc_i(64, 0, F3_ADD, 15, OPC_OP_IMM), 15, 32'h0000_0040, 1'b1, 1'b0);
        add_row(32'h8c, enc_s(8, 1, 15), 0, 32'h0, 1'b0, 1'b0);
        add_row(32'h90, enc_i(8, 15, F3_WORD, 16, OPC_LOAD), 16, 32'h1234_5000, 1'b1, 1'b0);
        add_row(32'h94, enc_i(-4, 15, F3_WORD, 17, OPC_LOAD), 17, dmem_init[15], 1'b1, 1'b0);
        if (trap_end) begin
            add_row(32'h98, 32'hffff_ffff, 0, 32'h0, 1'b0, 1'b1); // unknown opcode
        end else begin
            add_row(32'h98, enc_i(1, 0, 3'b000, 0, OPC_SYSTEM), 0, 32'h0, 1'b0, 1'b1);
        end
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        inst_rdata = '0;
        data_rdata = '0;
        exp_trap   = 1'b0;
        n_rows     = 0;
        timeouts   = 0;
        limit      = 0;
        void'($urandom(32'h0acdc4cb));
        for (int i = 0; i < DEPTH; i++) begin
            dmem_init[i] = $urandom;
        end
        for (int run = 0; run < 2; run++) begin
            build_table(run == 1);
            exp_trap = (run == 1);
            limit    = 6 * n_rows + 64;
            for (int i = 0; i < DEPTH; i++) begin
                imem[i] = {25'(i), 7'h00}; // unused words decode as invalid
                dmem[i] = dmem_init[i];
            end
            for (int r = 0; r < n_rows; r++) begin
                imem[exp_pc[r][7:2]] = exp_inst[r];
            end
            @(posedge clk);
            #1 arst_n = 1'b0;
            repeat (16) @(posedge clk);
            #1 arst_n = 1'b1;
            while (!chk_done && cycles < limit) begin
                @(posedge clk);
            end
            if (!chk_done) begin
                $display("timeout: core did not halt within %0d cycles in run %0d", limit, run);
                timeouts++;
                break;
            end
            repeat (8) @(posedge clk); // catch stray retires after halt
        end
        $display("checks done: %0d compare errors, %0d timeouts", err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/idu.sv
hdl/regfile.sv
hdl/exu.sv
hdl/pc_unit.sv
hdl/core_ctrl.sv
hdl/core_top.sv
tb/tb_checker.sv
tb/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
TOP       := tb_top
FILELIST  := files.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir
